// ==== ila_capture.sv ====
module ila_capture
    import ila_types_pkg::*;
#(
    parameter int MAX_LINES = 16
) (
    input  logic                         clk,
    input  logic                         rst,
    input  line_t                        line_in,
    input  logic                         line_valid,
    input  logic                         line_keep,
    input  logic                         trigger,
    input  logic                         arm,
    input  logic [$clog2(MAX_LINES):0]   burst_len,
    input  logic                         filter_en,
    output logic                         wr_en,
    output logic [$clog2(MAX_LINES)-1:0] wr_addr,
    output line_t                        wr_line,
    output logic [$clog2(MAX_LINES):0]   line_count,
    output logic                         armed,
    output logic                         storing,
    output logic                         full
);

    cap_state_t                 state;
    logic [$clog2(MAX_LINES):0] count;
    logic                       qualified;
    logic                       store;

    assign qualified = line_valid && (!filter_en || line_keep);

    // the trigger cycle's own line is the first candidate.
    assign store = qualified && (state == STORING || (state == ARMED && trigger));

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
            count <= '0;
        end else if (arm) begin
            state <= ARMED;  // restart from any state.
            count <= '0;
        end else if (store) begin
            count <= count + 1'b1;
            if (count + 1'b1 >= burst_len) begin
                state <= FULL;
            end else begin
                state <= STORING;
            end
        end else if (state == ARMED && trigger) begin
            state <= STORING;
        end
    end

    // memory takes the line on the same edge that counts it.
    assign wr_en   = store;
    assign wr_addr = count[$clog2(MAX_LINES)-1:0];
    assign wr_line = line_in;

    assign line_count = count;
    assign armed      = (state == ARMED);
    assign storing    = (state == STORING);
    assign full       = (state == FULL);

endmodule

// ==== ila_checker.sv ====
module ila_checker (
    input logic clk,
    input logic rst,
    input logic wb_cyc,
    input logic wb_stb,
    input logic wb_ack,
    input logic sample_valid,
    input logic full
);
    timeunit 1ns;
    timeprecision 1ps;

    int fail_count = 0;  // summed into the final verdict.

    ack_in_request: assert property (@(posedge clk) disable iff (rst)
        wb_ack |-> (wb_cyc && wb_stb))
        else begin
            $error("wb_ack raised outside an active request");
            fail_count++;
        end

    ack_one_cycle: assert property (@(posedge clk) disable iff (rst)
        wb_ack |=> !wb_ack)
        else begin
            $error("wb_ack held high for two cycles");
            fail_count++;
        end

    // outputs idle right after reset.
    reset_idle: assert property (@(posedge clk)
        rst |=> (!wb_ack && !sample_valid && !full))
        else begin
            $error("wb_ack, sample_valid or full high after reset");
            fail_count++;
        end

endmodule

bind ila_top ila_checker u_checker (
    .clk(clk),
    .rst(rst),
    .wb_cyc(wb_cyc),
    .wb_stb(wb_stb),
    .wb_ack(wb_ack),
    .sample_valid(sample_valid),
    .full(full)
);

// ==== ila_line_buffer.sv ====
module ila_line_buffer
    import ila_types_pkg::*;
#(
    parameter int MAX_LINES = 16
) (
    input  logic                         clk,
    input  logic                         wr_en,
    input  logic [$clog2(MAX_LINES)-1:0] wr_addr,
    input  line_t                        wr_line,
    input  logic [$clog2(MAX_LINES)-1:0] rd_addr,
    output line_t                        rd_line
);

    line_t mem [MAX_LINES];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_line;
        end
    end

    // registered read, old data on a same-address write.
    always_ff @(posedge clk) begin
        rd_line <= mem[rd_addr];
    end

endmodule

// ==== ila_regmap_pkg.sv ====
package ila_regmap_pkg;

    typedef logic [3:0]  wb_adr_t;   // word address.
    typedef logic [31:0] wb_data_t;

    localparam wb_adr_t REG_CTRL   = 4'd0;  // read/write.
    localparam wb_adr_t REG_ARM    = 4'd1;  // any write arms.
    localparam wb_adr_t REG_STATUS = 4'd2;
    localparam wb_adr_t REG_SAMPLE = 4'd3;  // each read pops one sample.

    // control fields.
    localparam int CTRL_LEN_LSB    = 0;
    localparam int CTRL_LEN_MSB    = 4;
    localparam int CTRL_FILTER_BIT = 8;

    // status fields.
    localparam int STAT_ARMED_BIT   = 0;
    localparam int STAT_STORING_BIT = 1;
    localparam int STAT_FULL_BIT    = 2;
    localparam int STAT_COUNT_LSB   = 8;
    localparam int STAT_COUNT_MSB   = 12;

    localparam int SAMPLE_LSB = 0;
    localparam int SAMPLE_MSB = 15;

endpackage

// ==== ila_sample_unpacker.sv ====
module ila_sample_unpacker
    import ila_types_pkg::*;
#(
    parameter int MAX_LINES = 16
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         arm,
    input  logic                         full,
    input  logic [$clog2(MAX_LINES):0]   line_count,
    output logic [$clog2(MAX_LINES)-1:0] rd_addr,
    input  line_t                        rd_line,
    input  logic                         pop,
    output sample_t                      sample,
    output logic                         sample_valid,
    output logic                         empty
);

    logic [$clog2(MAX_LINES):0] line_ptr;  // next line to load.
    slot_t                      slot;
    line_t                      cur_line;
    logic                       cur_valid;
    logic                       primed;
    logic                       more;
    logic                       load;

    // rd_line already holds line_ptr's line while the current one shifts out.
    assign rd_addr = line_ptr[$clog2(MAX_LINES)-1:0];
    assign more    = (line_ptr < line_count);
    assign load    = full && primed && !cur_valid && more;  // primed covers the last write.

    always_ff @(posedge clk) begin
        if (rst || arm) begin
            line_ptr  <= '0;
            slot      <= '0;
            cur_valid <= 1'b0;
            primed    <= 1'b0;
        end else begin
            primed <= full;
            if (load) begin
                cur_valid <= 1'b1;
                line_ptr  <= line_ptr + 1'b1;
            end else if (pop && cur_valid) begin
                if (slot == slot_t'(SAMPLES_PER_LINE - 1)) begin
                    cur_valid <= 1'b0;  // line done.
                    slot      <= '0;
                end else begin
                    slot <= slot + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            cur_line <= rd_line;
        end
    end

    assign sample       = cur_line[slot*SAMPLE_WIDTH +: SAMPLE_WIDTH];  // lowest first.
    assign sample_valid = cur_valid;
    assign empty        = !cur_valid && !(full && more);

endmodule

// ==== ila_tb.sv ====
module ila_tb
    import ila_types_pkg::*;
    import ila_regmap_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_NS        = 40;
    localparam int SAMPLE_READS  = 80 + 160 + 80 + 2;  // all sample reads of the run.
    localparam int READ_BOUND    = 10;                 // cycles per read.
    localparam int MARGIN_CYCLES = 2000;

    logic     clk;
    logic     rst;
    line_t    line_in;
    logic     line_valid;
    logic     line_keep;
    logic     trigger;
    logic     wb_cyc;
    logic     wb_stb;
    logic     wb_we;
    wb_adr_t  wb_adr;
    wb_data_t wb_dat_w;
    wb_data_t wb_dat_r;
    logic     wb_ack;

    line_t    probe_table [16];
    string    current_test = "reset";
    int       test_errors;
    int       passed = 0;
    int       failed = 0;
    int       checker_fails;
    wb_data_t rd;

    ila_top #(.MAX_LINES(16)) ila_top_i (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_NS / 2) clk = ~clk;
    end

    initial begin
        #((SAMPLE_READS * READ_BOUND + MARGIN_CYCLES) * CLK_NS);
        $display("watchdog expired, test %s never finished", current_test);
        $display("Regression failed");
        $finish;
    end

    // master holds the request until the edge that samples ack.
    task automatic transfer(input wb_adr_t adr, input logic write, input wb_data_t wdata,
                            output wb_data_t rdata);
        @(posedge clk);
        #2;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = write;
        wb_adr   = adr;
        wb_dat_w = wdata;
        do begin
            @(posedge clk);
            #1;
        end while (!wb_ack);
        rdata = wb_dat_r;
        @(posedge clk);
        #2;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic write_reg(input wb_adr_t adr, input wb_data_t data);
        wb_data_t unused;
        transfer(adr, 1'b1, data, unused);
    endtask

    task automatic read_reg(input wb_adr_t adr, output wb_data_t data);
        transfer(adr, 1'b0, '0, data);
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("** Error at %0t: %s expected %h, got %h", $time, name, expected, actual);
            test_errors++;
        end
    endtask

    // table line n on the n-th cycle after trigger, keep on even n.
    task automatic drive_probes();
        for (int n = 0; n < 16; n++) begin
            @(posedge clk);
            #2;
            trigger    = (n == 0);
            line_in    = probe_table[n];
            line_valid = 1'b1;
            line_keep  = (n % 2 == 0);
        end
        @(posedge clk);
        #2;
        line_valid = 1'b0;
        line_keep  = 1'b0;
        line_in    = '0;
    endtask

    task automatic begin_test(input string name);
        current_test = name;
        test_errors  = 0;
    endtask

    task automatic end_test();
        if (test_errors == 0) begin
            passed++;
            $display("test %s: ok", current_test);
        end else begin
            failed++;
            $display("test %s: %0d mismatches", current_test, test_errors);
        end
    endtask

    task automatic run_burst(input string name, input int burst, input bit filter);
        int       lines[$];
        int       polls;
        wb_data_t data;
        begin_test(name);
        for (int n = 0; n < 16; n++) begin
            if ((!filter || n % 2 == 0) && lines.size() < burst) lines.push_back(n);
        end
        write_reg(REG_CTRL, (wb_data_t'(filter) << CTRL_FILTER_BIT) | wb_data_t'(burst));
        write_reg(REG_ARM, '0);
        read_reg(REG_STATUS, data);
        check_value("status.armed", 1, data[STAT_ARMED_BIT]);
        fork
            drive_probes();
            begin
                repeat (2) @(posedge clk);  // lands mid-burst in every test.
                read_reg(REG_STATUS, data);
            end
        join
        check_value("status.storing", 1, data[STAT_STORING_BIT]);
        polls = 0;
        data  = '0;
        while (!data[STAT_FULL_BIT] && polls < 20) begin
            read_reg(REG_STATUS, data);
            polls++;
        end
        check_value("status.full", 1, data[STAT_FULL_BIT]);
        check_value("status.count", burst, data[STAT_COUNT_MSB:STAT_COUNT_LSB]);
        foreach (lines[k]) begin
            for (int s = 0; s < SAMPLES_PER_LINE; s++) begin
                read_reg(REG_SAMPLE, data);
                check_value($sformatf("wb_dat_r line %0d slot %0d", lines[k], s),
                            probe_table[lines[k]][s*SAMPLE_WIDTH +: SAMPLE_WIDTH], data);
            end
        end
        end_test();
    endtask

    initial begin
        void'($urandom(32'hcaff_80ed));
        foreach (probe_table[i]) begin
            for (int w = 0; w < LINE_WIDTH / 32; w++) probe_table[i][w*32 +: 32] = $urandom();
        end
        rst        = 1'b1;
        line_in    = '0;
        line_valid = 1'b0;
        line_keep  = 1'b0;
        trigger    = 1'b0;
        wb_cyc     = 1'b0;
        wb_stb     = 1'b0;
        wb_we      = 1'b0;
        wb_adr     = '0;
        wb_dat_w   = '0;
        repeat (10) @(posedge clk);
        #2;
        rst = 1'b0;

        begin_test("trigger_before_arm");
        drive_probes();
        read_reg(REG_STATUS, rd);
        check_value("status.count", 0, rd[STAT_COUNT_MSB:STAT_COUNT_LSB]);
        check_value("status.full", 0, rd[STAT_FULL_BIT]);
        read_reg(REG_SAMPLE, rd);
        check_value("wb_dat_r empty", 0, rd);
        end_test();

        run_burst("burst_5", 5, 1'b0);
        run_burst("burst_10", 10, 1'b0);
        run_burst("filter_5", 5, 1'b1);

        begin_test("read_past_end");
        read_reg(REG_SAMPLE, rd);
        check_value("wb_dat_r past end", 0, rd);
        end_test();

        begin_test("ctrl_readback");
        write_reg(REG_CTRL, 32'h107);
        read_reg(REG_CTRL, rd);
        check_value("ctrl", 32'h107, rd);
        write_reg(REG_CTRL, 32'h0);  // zero length clamps to full depth.
        read_reg(REG_CTRL, rd);
        check_value("ctrl", 32'h10, rd);
        end_test();

        checker_fails = ila_top_i.u_checker.fail_count;
        $display("tests passed %0d, failed %0d, assertion failures %0d",
                 passed, failed, checker_fails);
        if (failed == 0 && checker_fails == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// ==== ila_top.sv ====
module ila_top
    import ila_types_pkg::*;
    import ila_regmap_pkg::*;
#(
    parameter int MAX_LINES = 16
) (
    input  logic     clk,
    input  logic     rst,
    input  line_t    line_in,
    input  logic     line_valid,
    input  logic     line_keep,
    input  logic     trigger,
    input  logic     wb_cyc,
    input  logic     wb_stb,
    input  logic     wb_we,
    input  wb_adr_t  wb_adr,
    input  wb_data_t wb_dat_w,
    output wb_data_t wb_dat_r,
    output logic     wb_ack
);

    localparam int AW = $clog2(MAX_LINES);

    logic          arm;
    logic [AW:0]   burst_len;
    logic          filter_en;
    logic          wr_en;
    logic [AW-1:0] wr_addr;
    line_t         wr_line;
    logic [AW:0]   line_count;
    logic          armed;
    logic          storing;
    logic          full;
    logic [AW-1:0] rd_addr;
    line_t         rd_line;
    sample_t       sample;
    logic          sample_valid;
    logic          empty;
    logic          pop;

    ila_wb_regs #(.MAX_LINES(MAX_LINES)) u_regs (
        .clk(clk), .rst(rst),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
        .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
        .arm(arm), .burst_len(burst_len), .filter_en(filter_en),
        .armed(armed), .storing(storing), .full(full), .line_count(line_count),
        .sample(sample), .sample_valid(sample_valid), .empty(empty), .pop(pop)
    );

    ila_capture #(.MAX_LINES(MAX_LINES)) u_capture (
        .clk(clk), .rst(rst),
        .line_in(line_in), .line_valid(line_valid), .line_keep(line_keep),
        .trigger(trigger), .arm(arm), .burst_len(burst_len), .filter_en(filter_en),
        .wr_en(wr_en), .wr_addr(wr_addr), .wr_line(wr_line),
        .line_count(line_count), .armed(armed), .storing(storing), .full(full)
    );

    ila_line_buffer #(.MAX_LINES(MAX_LINES)) u_buffer (
        .clk(clk), .wr_en(wr_en), .wr_addr(wr_addr), .wr_line(wr_line),
        .rd_addr(rd_addr), .rd_line(rd_line)
    );

    ila_sample_unpacker #(.MAX_LINES(MAX_LINES)) u_unpacker (
        .clk(clk), .rst(rst), .arm(arm), .full(full), .line_count(line_count),
        .rd_addr(rd_addr), .rd_line(rd_line), .pop(pop),
        .sample(sample), .sample_valid(sample_valid), .empty(empty)
    );

endmodule

// ==== ila_types_pkg.sv ====
package ila_types_pkg;

    localparam int LINE_WIDTH       = 256;
    localparam int SAMPLE_WIDTH     = 16;
    localparam int SAMPLES_PER_LINE = LINE_WIDTH / SAMPLE_WIDTH;

    // one probe line as presented by the fabric.
    typedef logic [LINE_WIDTH-1:0] line_t;

    // one host-visible sample, a slice of a line.
    typedef logic [SAMPLE_WIDTH-1:0] sample_t;

    typedef logic [$clog2(SAMPLES_PER_LINE)-1:0] slot_t;  // sample index within a line.

    // capture sequence, one pass per arm.
    typedef enum logic [1:0] {
        IDLE,
        ARMED,
        STORING,
        FULL
    } cap_state_t;

endpackage

// ==== ila_wb_regs.sv ====
module ila_wb_regs
    import ila_regmap_pkg::*;
    import ila_types_pkg::*;
#(
    parameter int MAX_LINES = 16
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       wb_cyc,
    input  logic                       wb_stb,
    input  logic                       wb_we,
    input  wb_adr_t                    wb_adr,
    input  wb_data_t                   wb_dat_w,
    output wb_data_t                   wb_dat_r,
    output logic                       wb_ack,
    output logic                       arm,
    output logic [$clog2(MAX_LINES):0] burst_len,
    output logic                       filter_en,
    input  logic                       armed,
    input  logic                       storing,
    input  logic                       full,
    input  logic [$clog2(MAX_LINES):0] line_count,
    input  sample_t                    sample,
    input  logic                       sample_valid,
    input  logic                       empty,
    output logic                       pop
);

    localparam int CW    = $clog2(MAX_LINES) + 1;
    localparam int LEN_W = CTRL_LEN_MSB - CTRL_LEN_LSB + 1;
    localparam int CNT_W = STAT_COUNT_MSB - STAT_COUNT_LSB + 1;

    logic             req;
    logic             done;  // acked, waiting for stb to drop.
    logic             sample_rd;
    logic             ready;
    logic             fire;
    logic [LEN_W-1:0] len_wr;
    wb_data_t         rdata;

    assign req       = wb_cyc && wb_stb;
    assign sample_rd = !wb_we && (wb_adr == REG_SAMPLE);
    assign ready     = !sample_rd || sample_valid || empty;  // sample reads may stall.
    assign fire      = req && !done && ready;
    assign pop       = fire && sample_rd && sample_valid;
    assign len_wr    = wb_dat_w[CTRL_LEN_MSB:CTRL_LEN_LSB];

    always_comb begin
        rdata = '0;
        case (wb_adr)
            REG_CTRL: begin
                rdata[CTRL_LEN_MSB:CTRL_LEN_LSB] = LEN_W'(burst_len);
                rdata[CTRL_FILTER_BIT]           = filter_en;
            end
            REG_STATUS: begin
                rdata[STAT_ARMED_BIT]                = armed;
                rdata[STAT_STORING_BIT]              = storing;
                rdata[STAT_FULL_BIT]                 = full;
                rdata[STAT_COUNT_MSB:STAT_COUNT_LSB] = CNT_W'(line_count);
            end
            REG_SAMPLE: begin
                if (sample_valid) begin
                    rdata[SAMPLE_MSB:SAMPLE_LSB] = sample;  // zero once empty.
                end
            end
            default: rdata = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_ack    <= 1'b0;
            done      <= 1'b0;
            arm       <= 1'b0;
            burst_len <= '0;
            filter_en <= 1'b0;
        end else begin
            wb_ack <= fire;
            arm    <= fire && wb_we && (wb_adr == REG_ARM);
            if (fire) begin
                done <= 1'b1;
            end else if (!wb_stb) begin
                done <= 1'b0;
            end
            if (fire && wb_we && (wb_adr == REG_CTRL)) begin
                filter_en <= wb_dat_w[CTRL_FILTER_BIT];
                if (len_wr == '0 || len_wr > MAX_LINES) begin
                    burst_len <= CW'(MAX_LINES);  // clamp.
                end else begin
                    burst_len <= CW'(len_wr);
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fire && !wb_we) begin
            wb_dat_r <= rdata;
        end
    end

endmodule

// ==== project.f ====
ila_types_pkg.sv
ila_regmap_pkg.sv
ila_capture.sv
ila_line_buffer.sv
ila_sample_unpacker.sv
ila_wb_regs.sv
ila_top.sv
ila_checker.sv
ila_tb.sv
